//--- Bender.yml
package:
  name: block_device_bridge

sources:
  - sd_block_pkg.sv
  - hdd_pkg.sv
  - hdd_request_fsm.sv
  - block_request_router.sv
  - image_mount_tracker.sv
  - block_device_bridge.sv
  - target: test
    files:
      - tb_block_device_bridge.sv

//--- block_device_bridge.sv
`timescale 1ns/10ps
`default_nettype none

// Bridge between the machine's disk hardware and the host block devices
// Disks on indices 0..NUM_HDD_UNITS-1, floppy next, one spare index last
module block_device_bridge
	import sd_block_pkg::*, hdd_pkg::*;
#(
	parameter int NUM_HDD_UNITS = 2
) (
	input  wire                               clk_sys,
	input  wire                               reset,
	// Machine side
	input  wire                               hdd_read,
	input  wire                               hdd_write,
	input  wire                               hdd_unit,
	input  wire hdd_sector_t                  hdd_sector,
	input  wire sd_byte_t                     hdd_ram_do,
	output wire                               cpu_wait,
	output wire                               hdd_ram_we,
	output hdd_status_t                       hdd_status,
	// Host side
	output sd_lba_t  [NUM_HDD_UNITS+1:0]      sd_lba,
	output wire      [NUM_HDD_UNITS+1:0]      sd_rd,
	output wire      [NUM_HDD_UNITS+1:0]      sd_wr,
	output sd_byte_t [NUM_HDD_UNITS+1:0]      sd_buff_din,
	input  wire      [NUM_HDD_UNITS+1:0]      sd_ack,
	input  wire                               sd_buff_wr,
	input  wire      [NUM_HDD_UNITS+1:0]      img_mounted,
	input  wire                               img_readonly,
	input  wire      [SD_IMG_SIZE_W-1:0]      img_size,
	// Floppy side
	input  wire woz_req_t                     woz_req,
	input  wire sd_byte_t                     woz_buff_din,
	output wire                               woz_ack,
	output wire                               woz_mounted
);

	// Active disk request and its acknowledge
	hdd_req_t hdd_req;
	wire      hdd_ack;

	hdd_request_fsm i_hdd_request_fsm (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.hdd_read  (hdd_read),
		.hdd_write (hdd_write),
		.hdd_unit  (hdd_unit),
		.hdd_ack   (hdd_ack),
		.hdd_req   (hdd_req),
		.cpu_wait  (cpu_wait)
	);

	block_request_router #(.NUM_HDD_UNITS(NUM_HDD_UNITS)) i_block_request_router (
		.hdd_req      (hdd_req),
		.hdd_sector   (hdd_sector),
		.hdd_ram_do   (hdd_ram_do),
		.sd_buff_wr   (sd_buff_wr),
		.sd_ack       (sd_ack),
		.woz_req      (woz_req),
		.woz_buff_din (woz_buff_din),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_buff_din  (sd_buff_din),
		.hdd_ack      (hdd_ack),
		.hdd_ram_we   (hdd_ram_we),
		.woz_ack      (woz_ack)
	);

	// Spare index has no image to track
	image_mount_tracker #(.NUM_HDD_UNITS(NUM_HDD_UNITS)) i_image_mount_tracker (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.img_mounted  (img_mounted[NUM_HDD_UNITS:0]),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.hdd_status   (hdd_status),
		.woz_mounted  (woz_mounted)
	);

endmodule

`default_nettype wire

//--- block_request_router.sv
`timescale 1ns/10ps
`default_nettype none

// Steers hard-disk and floppy requests onto host device indices
// Indices 0..NUM_HDD_UNITS-1 are disks, then floppy, then an unused slot
module block_request_router
	import sd_block_pkg::*, hdd_pkg::*;
#(
	parameter int NUM_HDD_UNITS = 2
) (
	input  wire hdd_req_t                      hdd_req,
	input  wire hdd_sector_t                   hdd_sector,
	input  wire sd_byte_t                      hdd_ram_do,
	input  wire                                sd_buff_wr,
	input  wire [NUM_HDD_UNITS+1:0]            sd_ack,
	input  wire woz_req_t                      woz_req,
	input  wire sd_byte_t                      woz_buff_din,
	output sd_lba_t  [NUM_HDD_UNITS+1:0]       sd_lba,
	output logic     [NUM_HDD_UNITS+1:0]       sd_rd,
	output logic     [NUM_HDD_UNITS+1:0]       sd_wr,
	output sd_byte_t [NUM_HDD_UNITS+1:0]       sd_buff_din,
	output logic                               hdd_ack,
	output logic                               hdd_ram_we,
	output logic                               woz_ack
);

	// Floppy slot directly after the disks
	localparam int WOZ_IDX  = NUM_HDD_UNITS;
	localparam int LAST_IDX = NUM_HDD_UNITS + 1;

	always_comb begin
		sd_rd       = '0;
		sd_wr       = '0;
		sd_lba      = '0;
		sd_buff_din = '0;
		for (int i = 0; i < NUM_HDD_UNITS; i++) begin
			// Only the active unit sees the strobes
			sd_rd[i]       = hdd_req.rd & (hdd_req.unit == i);
			sd_wr[i]       = hdd_req.wr & (hdd_req.unit == i);
			// All disks share the sector and buffer, zero extended
			sd_lba[i]      = sd_lba_t'(hdd_sector);
			sd_buff_din[i] = hdd_ram_do;
		end
		// Floppy controller passes straight through
		sd_rd[WOZ_IDX]       = woz_req.rd;
		sd_wr[WOZ_IDX]       = woz_req.wr;
		sd_lba[WOZ_IDX]      = woz_req.lba;
		sd_buff_din[WOZ_IDX] = woz_buff_din;
		// Spare slot stays quiet
		sd_rd[LAST_IDX]       = 1'b0;
		sd_wr[LAST_IDX]       = 1'b0;
		sd_lba[LAST_IDX]      = '0;
		sd_buff_din[LAST_IDX] = '0;
	end

	// Ack of the unit being served
	assign hdd_ack    = sd_ack[hdd_req.unit];
	// Buffer writes count only while that unit is acknowledged
	assign hdd_ram_we = sd_buff_wr & hdd_ack;
	assign woz_ack    = sd_ack[WOZ_IDX];

	// At most one disk index requests at a time
	always_comb begin
		a_one_hdd_index: assert final ($onehot0(sd_rd[NUM_HDD_UNITS-1:0]
			| sd_wr[NUM_HDD_UNITS-1:0]))
			else $error("more than one disk index requesting");
	end

endmodule

`default_nettype wire

//--- hdd_pkg.sv
`default_nettype none

// Hard-disk side of the bridge
// Field widths below are sized for two units
package hdd_pkg;

	// Sector number as driven by the disk controller
	typedef logic [15:0] hdd_sector_t;

	// Request controller state
	// Idle waits for a pending request, busy runs the ack handshake
	typedef enum logic {
		HDD_IDLE = 1'b0,
		HDD_BUSY = 1'b1
	} hdd_state_e;

	// Request toward the router
	// rd and wr may both be set when both pulses were merged
	typedef struct packed {
		logic rd;
		logic wr;
		logic unit;
	} hdd_req_t;

	// Per-unit status bits seen by the machine
	// Bit i belongs to unit i
	typedef struct packed {
		logic [1:0] mounted;
		logic [1:0] protect;
	} hdd_status_t;

endpackage

`default_nettype wire

//--- hdd_request_fsm.sv
`timescale 1ns/10ps
`default_nettype none

// Latches hard-disk read and write pulses and runs the host handshake
// Strobe rises from pending, falls on the ack rising edge
// Transaction ends on the ack falling edge
module hdd_request_fsm
	import hdd_pkg::*;
(
	input  wire      clk_sys,
	input  wire      reset,
	input  wire      hdd_read,
	input  wire      hdd_write,
	input  wire      hdd_unit,
	input  wire      hdd_ack,
	output hdd_req_t hdd_req,
	output logic     cpu_wait
);

	hdd_state_e state;

	// Pending latches for merged pulses
	logic rd_pending;
	logic wr_pending;

	// Strobes toward the router
	logic rd_strobe;
	logic wr_strobe;

	// Unit of the current or next transaction
	logic active_unit;

	// Previous ack for edge detection
	logic ack_d;

	logic pulse;
	logic any_pending;
	logic take;
	logic ack_rise;
	logic ack_fall;

	assign pulse       = hdd_read | hdd_write;
	assign any_pending = rd_pending | wr_pending;
	// Idle with something pending starts a transaction
	assign take        = (state == HDD_IDLE) & any_pending;
	assign ack_rise    = ~ack_d & hdd_ack;
	assign ack_fall    = ack_d & ~hdd_ack;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= HDD_IDLE;
			rd_pending  <= 1'b0;
			wr_pending  <= 1'b0;
			rd_strobe   <= 1'b0;
			wr_strobe   <= 1'b0;
			cpu_wait    <= 1'b0;
			active_unit <= 1'b0;
			ack_d       <= 1'b0;
		end else begin
			ack_d <= hdd_ack;

			// Pending is handed to the strobes when taken
			// Pulses during busy wait here for the next transaction
			if (take) begin
				rd_pending <= hdd_read;
				wr_pending <= hdd_write;
			end else begin
				rd_pending <= rd_pending | hdd_read;
				wr_pending <= wr_pending | hdd_write;
			end

			// Unit only follows a fresh pulse on an idle controller
			if (pulse && state == HDD_IDLE && !any_pending)
				active_unit <= hdd_unit;

			case (state)
				HDD_IDLE: begin
					if (any_pending) begin
						state     <= HDD_BUSY;
						rd_strobe <= rd_pending;
						wr_strobe <= wr_pending;
						cpu_wait  <= 1'b1;
					end
				end
				HDD_BUSY: begin
					// Host took the request
					if (ack_rise) begin
						rd_strobe <= 1'b0;
						wr_strobe <= 1'b0;
					end else if (ack_fall) begin
						// Sector moved, release the CPU
						state    <= HDD_IDLE;
						cpu_wait <= 1'b0;
					end
				end
				default: state <= HDD_IDLE;
			endcase
		end
	end

	assign hdd_req.rd   = rd_strobe;
	assign hdd_req.wr   = wr_strobe;
	assign hdd_req.unit = active_unit;

	// Host must raise ack before dropping it, else a strobe outlives the transaction
	a_no_req_when_idle: assert property (@(posedge clk_sys) disable iff (reset)
		(state == HDD_IDLE) |-> !(hdd_req.rd || hdd_req.wr))
		else $error("hdd request strobe high while idle");

	// CPU held exactly for the length of a transaction
	a_wait_matches_busy: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_wait == (state == HDD_BUSY))
		else $error("cpu_wait out of step with controller state");

endmodule

`default_nettype wire

//--- image_mount_tracker.sv
`timescale 1ns/10ps
`default_nettype none

// Tracks image mounts reported by the host
// Disk units update on every strobe, floppy only on a rising edge
module image_mount_tracker
	import sd_block_pkg::*, hdd_pkg::*;
#(
	parameter int NUM_HDD_UNITS = 2
) (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire [NUM_HDD_UNITS:0]     img_mounted,
	input  wire                       img_readonly,
	input  wire [SD_IMG_SIZE_W-1:0]   img_size,
	output hdd_status_t               hdd_status,
	output logic                      woz_mounted
);

	localparam int WOZ_IDX = NUM_HDD_UNITS;

	// Empty image means eject
	logic image_present;
	// Floppy strobe one cycle back
	logic woz_strobe_d;
	logic woz_strobe_rise;

	assign image_present   = |img_size;
	assign woz_strobe_rise = img_mounted[WOZ_IDX] & ~woz_strobe_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdd_status   <= '0;
			woz_strobe_d <= 1'b0;
			woz_mounted  <= 1'b0;
		end else begin
			for (int i = 0; i < NUM_HDD_UNITS; i++) begin
				// Size and readonly are valid with the strobe
				if (img_mounted[i]) begin
					hdd_status.mounted[i] <= image_present;
					hdd_status.protect[i] <= img_readonly;
				end
			end

			woz_strobe_d <= img_mounted[WOZ_IDX];
			// A held strobe does not retrigger
			if (woz_strobe_rise)
				woz_mounted <= image_present;
		end
	end

endmodule

`default_nettype wire

//--- sd_block_pkg.sv
`default_nettype none

// Host side of the block-device interface
// One sector is 512 bytes, addressed by LBA per device index
package sd_block_pkg;

	// Sector address as the host sees it
	typedef logic [31:0] sd_lba_t;

	// One byte of the shared sector buffer
	typedef logic [7:0] sd_byte_t;

	// Byte offset inside a 512-byte sector
	typedef logic [8:0] sd_buff_addr_t;

	// Width of the image size reported on mount
	localparam int SD_IMG_SIZE_W = 64;

	// Request from the external floppy controller
	// rd and wr are levels that drop on the host acknowledge
	typedef struct packed {
		logic    rd;
		logic    wr;
		sd_lba_t lba;
	} woz_req_t;

endpackage

`default_nettype wire

//--- tb_block_device_bridge.sv
`timescale 1ns/10ps
`default_nettype none

// Directed testbench for the block-device bridge
// Tests play the host and drive ack themselves
module tb_block_device_bridge
	import sd_block_pkg::*, hdd_pkg::*;
();

	localparam int NUM_HDD_UNITS = 2;
	localparam int NIDX          = NUM_HDD_UNITS + 2;
	localparam int WAIT_LIMIT    = 50;

	logic                     clk_sys;
	logic                     reset;
	logic                     hdd_read;
	logic                     hdd_write;
	logic                     hdd_unit;
	hdd_sector_t              hdd_sector;
	sd_byte_t                 hdd_ram_do;
	logic                     cpu_wait;
	logic                     hdd_ram_we;
	hdd_status_t              hdd_status;
	sd_lba_t  [NIDX-1:0]      sd_lba;
	logic     [NIDX-1:0]      sd_rd;
	logic     [NIDX-1:0]      sd_wr;
	logic     [NIDX-1:0]      sd_ack;
	logic     [NIDX-1:0]      img_mounted;
	sd_byte_t [NIDX-1:0]      sd_buff_din;
	logic                     sd_buff_wr;
	logic                     img_readonly;
	logic [SD_IMG_SIZE_W-1:0] img_size;
	woz_req_t                 woz_req;
	sd_byte_t                 woz_buff_din;
	logic                     woz_ack;
	logic                     woz_mounted;

	// Bookkeeping for the report
	string       cur_test;
	int          errors;
	int          errors_at_start;
	int          tests_run;
	int          tests_failed;
	logic [31:0] lfsr_state;

	block_device_bridge #(.NUM_HDD_UNITS(NUM_HDD_UNITS)) i_block_device_bridge (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.hdd_read     (hdd_read),
		.hdd_write    (hdd_write),
		.hdd_unit     (hdd_unit),
		.hdd_sector   (hdd_sector),
		.hdd_ram_do   (hdd_ram_do),
		.cpu_wait     (cpu_wait),
		.hdd_ram_we   (hdd_ram_we),
		.hdd_status   (hdd_status),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_buff_din  (sd_buff_din),
		.sd_ack       (sd_ack),
		.sd_buff_wr   (sd_buff_wr),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.woz_req      (woz_req),
		.woz_buff_din (woz_buff_din),
		.woz_ack      (woz_ack),
		.woz_mounted  (woz_mounted)
	);

	// 4 ns clock
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Galois LFSR stepped once per bit taken
	// Bits enter the result MSB first
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val        = {val[30:0], lfsr_state[0]};
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return val;
	endfunction

	task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			errors++;
			$display("mismatch %s %s: expected %0h actual %0h", cur_test, what, exp, act);
		end
	endtask

	// Selects sd_rd for 0, sd_wr for 1 and cpu_wait otherwise
	function automatic logic probe(input int sel, input int idx);
		case (sel)
			0:       return sd_rd[idx];
			1:       return sd_wr[idx];
			default: return cpu_wait;
		endcase
	endfunction

	// Poll on falling edges until the output reaches val
	task automatic wait_level(input int sel, input int idx, input logic val, input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (probe(sel, idx) !== val && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (probe(sel, idx) !== val) begin
			$display("%s: timed out waiting for %s", cur_test, what);
			$display("TEST FAIL");
			$finish;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test        = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == errors_at_start) begin
			$display("%s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("%s: %0d mismatches", cur_test, errors - errors_at_start);
		end
	endtask

	// Mount strobe of one cycle
	// Returns at the falling edge after the update
	task automatic mount_strobe(input logic [NIDX-1:0] mask, input logic ro,
		input logic [63:0] size);
		@(posedge clk_sys);
		img_mounted  <= mask;
		img_readonly <= ro;
		img_size     <= size;
		@(posedge clk_sys);
		img_mounted <= '0;
		@(negedge clk_sys);
	endtask

	task automatic reset_values();
		begin_test("reset");
		@(negedge clk_sys);
		check("sd_rd", 0, sd_rd);
		check("sd_wr", 0, sd_wr);
		check("cpu_wait", 0, cpu_wait);
		check("hdd_status", 0, hdd_status);
		end_test();
	endtask

	task automatic mount_tracking();
		logic [63:0] size;
		begin_test("mount");
		size = {rand_bits(32), rand_bits(32)} | 64'h1;
		// Mounted bits sit above the protect bits in the status
		mount_strobe(4'b0001, 1'b1, size);
		check("unit 0 protected", 4'b0101, hdd_status);
		mount_strobe(4'b0010, 1'b0, size);
		check("unit 1 mounted", 4'b1101, hdd_status);
		mount_strobe(4'b0010, 1'b0, '0);
		check("unit 1 ejected", 4'b0101, hdd_status);
		end_test();
	endtask

	task automatic hdd_read_unit1();
		hdd_sector_t sector;
		begin_test("hdd read");
		sector = hdd_sector_t'(rand_bits(16));
		@(posedge clk_sys);
		hdd_read   <= 1'b1;
		hdd_unit   <= 1'b1;
		hdd_sector <= sector;
		@(posedge clk_sys);
		hdd_read <= 1'b0;
		// Strobe and wait come up two edges after the pulse
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("sd_rd", 4'b0010, sd_rd);
		check("cpu_wait set", 1'b1, cpu_wait);
		check("sd_lba[1]", {16'h0, sector}, sd_lba[1]);
		@(posedge clk_sys);
		sd_ack <= 4'b0010;
		wait_level(0, 1, 1'b0, "sd_rd[1] to fall");
		@(posedge clk_sys);
		sd_ack <= '0;
		@(negedge clk_sys);
		check("cpu_wait held", 1'b1, cpu_wait);
		@(negedge clk_sys);
		check("cpu_wait released", 1'b0, cpu_wait);
		end_test();
	endtask

	task automatic hdd_write_queued();
		sd_byte_t data;
		begin_test("hdd write");
		data = sd_byte_t'(rand_bits(8));
		@(posedge clk_sys);
		hdd_write  <= 1'b1;
		hdd_unit   <= 1'b0;
		hdd_ram_do <= data;
		@(posedge clk_sys);
		hdd_write <= 1'b0;
		wait_level(1, 0, 1'b1, "sd_wr[0] to rise");
		check("sd_wr", 4'b0001, sd_wr);
		check("sd_buff_din[0]", data, sd_buff_din[0]);
		// Read pulse while busy with unit 1 on the input
		@(posedge clk_sys);
		hdd_read <= 1'b1;
		hdd_unit <= 1'b1;
		@(posedge clk_sys);
		hdd_read   <= 1'b0;
		sd_ack     <= 4'b0001;
		sd_buff_wr <= 1'b1;
		@(negedge clk_sys);
		check("ram_we on write", 1'b1, hdd_ram_we);
		@(posedge clk_sys);
		sd_buff_wr <= 1'b0;
		@(negedge clk_sys);
		check("ram_we no write", 1'b0, hdd_ram_we);
		wait_level(1, 0, 1'b0, "sd_wr[0] to fall");
		@(posedge clk_sys);
		sd_ack     <= '0;
		sd_buff_wr <= 1'b1;
		@(negedge clk_sys);
		check("ram_we after ack", 1'b0, hdd_ram_we);
		// Queued read stays on unit 0
		wait_level(0, 0, 1'b1, "queued read on index 0");
		check("queued sd_rd", 4'b0001, sd_rd);
		check("queued sd_wr", 0, sd_wr);
		@(posedge clk_sys);
		sd_buff_wr <= 1'b0;
		sd_ack     <= 4'b0001;
		wait_level(0, 0, 1'b0, "queued read to fall");
		@(posedge clk_sys);
		sd_ack <= '0;
		wait_level(2, 0, 1'b0, "cpu_wait to fall");
		end_test();
	endtask

	task automatic floppy_channel();
		sd_lba_t     lba;
		sd_byte_t    data;
		logic [63:0] size;
		begin_test("floppy");
		lba  = rand_bits(32);
		data = sd_byte_t'(rand_bits(8));
		size = {rand_bits(32), rand_bits(32)} | 64'h1;
		@(posedge clk_sys);
		woz_req.rd   <= 1'b1;
		woz_req.wr   <= 1'b0;
		woz_req.lba  <= lba;
		woz_buff_din <= data;
		@(negedge clk_sys);
		check("sd_rd", 4'b0100, sd_rd);
		check("sd_lba[2]", lba, sd_lba[2]);
		check("sd_buff_din[2]", data, sd_buff_din[2]);
		check("spare index", 0, {sd_lba[3], sd_buff_din[3]});
		// Write strobe from the floppy side while the host acknowledges
		@(posedge clk_sys);
		woz_req.rd <= 1'b0;
		woz_req.wr <= 1'b1;
		sd_ack     <= 4'b0100;
		@(negedge clk_sys);
		check("woz_ack", 1'b1, woz_ack);
		check("sd_wr", 4'b0100, sd_wr);
		check("sd_rd dropped", 0, sd_rd);
		@(posedge clk_sys);
		woz_req      <= '0;
		sd_ack       <= '0;
		img_mounted  <= 4'b0100;
		img_size     <= size;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("woz mounted", 1'b1, woz_mounted);
		// Held strobe with an empty size must not retrigger
		@(posedge clk_sys);
		img_size <= '0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check("woz held strobe", 1'b1, woz_mounted);
		@(posedge clk_sys);
		img_mounted <= '0;
		mount_strobe(4'b0100, 1'b0, '0);
		check("woz ejected", 1'b0, woz_mounted);
		end_test();
	endtask

	initial begin
		lfsr_state   = 32'h8015_9cdf;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset        = 1'b1;
		hdd_read     = 1'b0;
		hdd_write    = 1'b0;
		hdd_unit     = 1'b0;
		hdd_sector   = '0;
		hdd_ram_do   = '0;
		sd_ack       = '0;
		sd_buff_wr   = 1'b0;
		img_mounted  = '0;
		img_readonly = 1'b0;
		img_size     = '0;
		woz_req      = '0;
		woz_buff_din = '0;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;

		reset_values();
		mount_tracking();
		hdd_read_unit1();
		hdd_write_queued();
		floppy_channel();

		$display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
sd_block_pkg.sv
hdd_pkg.sv
hdd_request_fsm.sv
block_request_router.sv
image_mount_tracker.sv
block_device_bridge.sv
tb_block_device_bridge.sv
